// ==== logic/bridge_pkg.sv ====
package bridge_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = 4;

    // memory map, base and size per region
    localparam logic [ADDR_WIDTH-1:0] MROM_BASE  = 32'h2000_0000; // read only
    localparam logic [ADDR_WIDTH-1:0] MROM_SIZE  = 32'h0000_1000;
    localparam logic [ADDR_WIDTH-1:0] UART_BASE  = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] UART_SIZE  = 32'h0000_1000;
    localparam logic [ADDR_WIDTH-1:0] SPI_BASE   = 32'h1000_1000;
    localparam logic [ADDR_WIDTH-1:0] SPI_SIZE   = 32'h0000_1000;
    localparam logic [ADDR_WIDTH-1:0] SRAM_BASE  = 32'h0f00_0000;
    localparam logic [ADDR_WIDTH-1:0] SRAM_SIZE  = 32'h0000_2000;
    localparam logic [ADDR_WIDTH-1:0] FLASH_BASE = 32'h3000_0000;
    localparam logic [ADDR_WIDTH-1:0] FLASH_SIZE = 32'h1000_0000;
    localparam logic [ADDR_WIDTH-1:0] CLINT_BASE = 32'h0200_0000; // read only
    localparam logic [ADDR_WIDTH-1:0] CLINT_SIZE = 32'h0001_0000;

    // shared by aw and ar
    typedef struct packed {
        logic [ADDR_WIDTH-1:0] addr;
        logic [2:0]            size;
        logic [2:0]            prot;
    } addr_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
    } wdata_t;

    typedef logic [1:0] bresp_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [1:0]            resp;
    } rdata_t;

    typedef enum logic [1:0] {
        GRANT_IDLE = 2'b00,
        GRANT_INST = 2'b01,
        GRANT_MEM  = 2'b10
    } grant_e;

    // offset compare, so base + size never has to fit
    function automatic logic in_region(
        input logic [ADDR_WIDTH-1:0] addr,
        input logic [ADDR_WIDTH-1:0] base,
        input logic [ADDR_WIDTH-1:0] size
    );
        return (addr >= base) && ((addr - base) < size);
    endfunction

endpackage

// ==== logic/master_arbiter.sv ====
`timescale 1ns/1ns

module master_arbiter (
    input  logic                  aclk,
    input  logic                  areset,
    input  logic                  inst_fetch_flag,
    input  logic                  mem_access_flag,

    input  logic                  lsu_awvalid,
    input  bridge_pkg::addr_req_t lsu_awreq,
    output logic                  lsu_awready,
    input  logic                  lsu_wvalid,
    input  bridge_pkg::wdata_t    lsu_w,
    output logic                  lsu_wready,
    output logic                  lsu_bvalid,
    output bridge_pkg::bresp_t    lsu_b,
    input  logic                  lsu_bready,
    input  logic                  lsu_arvalid,
    input  bridge_pkg::addr_req_t lsu_arreq,
    output logic                  lsu_arready,
    output logic                  lsu_rvalid,
    output bridge_pkg::rdata_t    lsu_r,
    input  logic                  lsu_rready,

    input  logic                  ifu_arvalid,
    input  bridge_pkg::addr_req_t ifu_arreq,
    output logic                  ifu_arready,
    output logic                  ifu_rvalid,
    output bridge_pkg::rdata_t    ifu_r,
    input  logic                  ifu_rready,

    output logic                  bus_awvalid,
    output bridge_pkg::addr_req_t bus_awreq,
    input  logic                  bus_awready,
    output logic                  bus_wvalid,
    output bridge_pkg::wdata_t    bus_w,
    input  logic                  bus_wready,
    input  logic                  bus_bvalid,
    input  bridge_pkg::bresp_t    bus_b,
    output logic                  bus_bready,
    output logic                  bus_arvalid,
    output bridge_pkg::addr_req_t bus_arreq,
    input  logic                  bus_arready,
    input  logic                  bus_rvalid,
    input  bridge_pkg::rdata_t    bus_r,
    output logic                  bus_rready
);
    import bridge_pkg::*;

    grant_e grant;
    logic   allow_lsu;
    logic   allow_ifu;

    // core never fetches and accesses memory at once, so one owner at a time
    always_ff @(posedge aclk) begin
        if (areset) begin
            grant <= GRANT_IDLE;
        end else begin
            case (grant)
                GRANT_IDLE: grant <= GRANT_INST;
                GRANT_INST: if (mem_access_flag) grant <= GRANT_MEM;
                GRANT_MEM:  if (inst_fetch_flag) grant <= GRANT_INST;
                default:    grant <= GRANT_IDLE;
            endcase
        end
    end

    assign allow_lsu = (grant == GRANT_MEM);
    assign allow_ifu = (grant == GRANT_INST);

    // write side, lsu only
    assign bus_awvalid = allow_lsu & lsu_awvalid;
    assign bus_awreq   = allow_lsu ? lsu_awreq : '0;
    assign lsu_awready = allow_lsu & bus_awready;
    assign bus_wvalid  = allow_lsu & lsu_wvalid;
    assign bus_w       = allow_lsu ? lsu_w : '0;
    assign lsu_wready  = allow_lsu & bus_wready;
    assign lsu_bvalid  = allow_lsu & bus_bvalid;
    assign lsu_b       = allow_lsu ? bus_b : '0;
    assign bus_bready  = allow_lsu & lsu_bready;

    // read side
    assign bus_arvalid = allow_lsu ? lsu_arvalid :
                         allow_ifu ? ifu_arvalid : 1'b0;
    assign bus_arreq   = allow_lsu ? lsu_arreq :
                         allow_ifu ? ifu_arreq : '0;
    assign bus_rready  = allow_lsu ? lsu_rready :
                         allow_ifu ? ifu_rready : 1'b0;

    assign lsu_arready = allow_lsu & bus_arready;
    assign lsu_rvalid  = allow_lsu & bus_rvalid;
    assign lsu_r       = allow_lsu ? bus_r : '0;

    assign ifu_arready = allow_ifu & bus_arready;
    assign ifu_rvalid  = allow_ifu & bus_rvalid;
    assign ifu_r       = allow_ifu ? bus_r : '0;

endmodule

// ==== logic/addr_decoder.sv ====
`timescale 1ns/1ns

module addr_decoder (
    input  logic                  bus_awvalid,
    input  bridge_pkg::addr_req_t bus_awreq,
    input  logic                  bus_arvalid,
    input  bridge_pkg::addr_req_t bus_arreq,
    output logic                  hit_soc,
    output logic                  hit_clint,
    output logic                  access_fault
);
    import bridge_pkg::*;

    logic [ADDR_WIDTH-1:0] aw_addr;
    logic [ADDR_WIDTH-1:0] ar_addr;
    logic                  wr_soc;
    logic                  rd_soc;
    logic                  rd_clint;

    assign aw_addr = bus_awreq.addr;
    assign ar_addr = bus_arreq.addr;

    // mrom is not writable
    assign wr_soc = bus_awvalid & (
                        in_region(aw_addr, UART_BASE, UART_SIZE) |
                        in_region(aw_addr, SPI_BASE, SPI_SIZE) |
                        in_region(aw_addr, SRAM_BASE, SRAM_SIZE) |
                        in_region(aw_addr, FLASH_BASE, FLASH_SIZE));

    assign rd_soc = bus_arvalid & (
                        in_region(ar_addr, MROM_BASE, MROM_SIZE) |
                        in_region(ar_addr, UART_BASE, UART_SIZE) |
                        in_region(ar_addr, SPI_BASE, SPI_SIZE) |
                        in_region(ar_addr, SRAM_BASE, SRAM_SIZE) |
                        in_region(ar_addr, FLASH_BASE, FLASH_SIZE));

    assign rd_clint = bus_arvalid & in_region(ar_addr, CLINT_BASE, CLINT_SIZE); // timer regs

    assign hit_soc   = wr_soc | rd_soc;
    assign hit_clint = rd_clint;

    // request outside every permitted region
    assign access_fault = (bus_awvalid | bus_arvalid) & ~(hit_soc | hit_clint);

endmodule

// ==== logic/slave_router.sv ====
`timescale 1ns/1ns

module slave_router (
    input  logic                                aclk,
    input  logic                                areset,
    input  logic                                hit_soc,
    input  logic                                hit_clint,

    input  logic                                bus_awvalid,
    input  bridge_pkg::addr_req_t               bus_awreq,
    output logic                                bus_awready,
    input  logic                                bus_wvalid,
    input  bridge_pkg::wdata_t                  bus_w,
    output logic                                bus_wready,
    output logic                                bus_bvalid,
    output bridge_pkg::bresp_t                  bus_b,
    input  logic                                bus_bready,
    input  logic                                bus_arvalid,
    input  bridge_pkg::addr_req_t               bus_arreq,
    output logic                                bus_arready,
    output logic                                bus_rvalid,
    output bridge_pkg::rdata_t                  bus_r,
    input  logic                                bus_rready,

    output logic                                soc_awvalid,
    output bridge_pkg::addr_req_t               soc_awreq,
    input  logic                                soc_awready,
    output logic                                soc_wvalid,
    output bridge_pkg::wdata_t                  soc_w,
    input  logic                                soc_wready,
    input  logic                                soc_bvalid,
    input  bridge_pkg::bresp_t                  soc_b,
    output logic                                soc_bready,
    output logic                                soc_arvalid,
    output bridge_pkg::addr_req_t               soc_arreq,
    input  logic                                soc_arready,
    input  logic                                soc_rvalid,
    input  bridge_pkg::rdata_t                  soc_r,
    output logic                                soc_rready,

    output logic                                clint_arvalid,
    output logic [bridge_pkg::ADDR_WIDTH-1:0]   clint_araddr,
    input  logic                                clint_arready,
    input  logic                                clint_rvalid,
    input  bridge_pkg::rdata_t                  clint_r,
    output logic                                clint_rready
);
    import bridge_pkg::*;

    logic soc_route_q;
    logic clint_route_q;
    logic soc_active;
    logic clint_active;
    logic soc_done;
    logic clint_done;

    // response handshake ends the transaction
    assign soc_done   = (soc_bvalid & soc_bready) | (soc_rvalid & soc_rready);
    assign clint_done = clint_rvalid & clint_rready; // read only target

    // route stays after the address phase until the response is taken
    always_ff @(posedge aclk) begin
        if (areset) begin
            soc_route_q <= 1'b0;
        end else if (soc_done) begin
            soc_route_q <= 1'b0;
        end else if (hit_soc) begin
            soc_route_q <= 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (areset) begin
            clint_route_q <= 1'b0;
        end else if (clint_done) begin
            clint_route_q <= 1'b0;
        end else if (hit_clint) begin
            clint_route_q <= 1'b1;
        end
    end

    assign soc_active   = hit_soc | soc_route_q;
    assign clint_active = ~soc_active & (hit_clint | clint_route_q); // soc wins

    // soc, full read and write
    assign soc_awvalid = soc_active & bus_awvalid;
    assign soc_awreq   = soc_active ? bus_awreq : '0;
    assign soc_wvalid  = soc_active & bus_wvalid;
    assign soc_w       = soc_active ? bus_w : '0;
    assign soc_bready  = soc_active & bus_bready;
    assign soc_arvalid = soc_active & bus_arvalid;
    assign soc_arreq   = soc_active ? bus_arreq : '0;
    assign soc_rready  = soc_active & bus_rready;

    // clint gets the address only
    assign clint_arvalid = clint_active & bus_arvalid;
    assign clint_araddr  = clint_active ? bus_arreq.addr : '0;
    assign clint_rready  = clint_active & bus_rready;

    // back toward the arbiter, zeros when nothing is routed
    assign bus_awready = soc_active & soc_awready;
    assign bus_wready  = soc_active & soc_wready;
    assign bus_bvalid  = soc_active & soc_bvalid;
    assign bus_b       = soc_active ? soc_b : '0;

    assign bus_arready = soc_active   ? soc_arready :
                         clint_active ? clint_arready : 1'b0;
    assign bus_rvalid  = soc_active   ? soc_rvalid :
                         clint_active ? clint_rvalid : 1'b0;
    assign bus_r       = soc_active   ? soc_r :
                         clint_active ? clint_r : '0;

endmodule

// ==== logic/axi_bridge.sv ====
`timescale 1ns/1ns

module axi_bridge (
    input  logic                                aclk,
    input  logic                                areset,
    input  logic                                inst_fetch_flag,
    input  logic                                mem_access_flag,
    output logic                                access_fault,

    input  logic                                lsu_awvalid,
    input  bridge_pkg::addr_req_t               lsu_awreq,
    output logic                                lsu_awready,
    input  logic                                lsu_wvalid,
    input  bridge_pkg::wdata_t                  lsu_w,
    output logic                                lsu_wready,
    output logic                                lsu_bvalid,
    output bridge_pkg::bresp_t                  lsu_b,
    input  logic                                lsu_bready,
    input  logic                                lsu_arvalid,
    input  bridge_pkg::addr_req_t               lsu_arreq,
    output logic                                lsu_arready,
    output logic                                lsu_rvalid,
    output bridge_pkg::rdata_t                  lsu_r,
    input  logic                                lsu_rready,

    input  logic                                ifu_arvalid,
    input  bridge_pkg::addr_req_t               ifu_arreq,
    output logic                                ifu_arready,
    output logic                                ifu_rvalid,
    output bridge_pkg::rdata_t                  ifu_r,
    input  logic                                ifu_rready,

    output logic                                soc_awvalid,
    output bridge_pkg::addr_req_t               soc_awreq,
    input  logic                                soc_awready,
    output logic                                soc_wvalid,
    output bridge_pkg::wdata_t                  soc_w,
    input  logic                                soc_wready,
    input  logic                                soc_bvalid,
    input  bridge_pkg::bresp_t                  soc_b,
    output logic                                soc_bready,
    output logic                                soc_arvalid,
    output bridge_pkg::addr_req_t               soc_arreq,
    input  logic                                soc_arready,
    input  logic                                soc_rvalid,
    input  bridge_pkg::rdata_t                  soc_r,
    output logic                                soc_rready,

    output logic                                clint_arvalid,
    output logic [bridge_pkg::ADDR_WIDTH-1:0]   clint_araddr,
    input  logic                                clint_arready,
    input  logic                                clint_rvalid,
    input  bridge_pkg::rdata_t                  clint_r,
    output logic                                clint_rready
);
    import bridge_pkg::*;

    // shared path between arbiter and router
    logic      bus_awvalid;
    addr_req_t bus_awreq;
    logic      bus_awready;
    logic      bus_wvalid;
    wdata_t    bus_w;
    logic      bus_wready;
    logic      bus_bvalid;
    bresp_t    bus_b;
    logic      bus_bready;
    logic      bus_arvalid;
    addr_req_t bus_arreq;
    logic      bus_arready;
    logic      bus_rvalid;
    rdata_t    bus_r;
    logic      bus_rready;
    logic      hit_soc;
    logic      hit_clint;

    master_arbiter u_master_arbiter (.*);

    addr_decoder u_addr_decoder (.*);

    slave_router u_slave_router (.*);

endmodule

// ==== test/clock_gen.sv ====
`timescale 1ns/1ns

module clock_gen (
    output logic aclk,
    output logic areset
);
    localparam int HALF_PERIOD = 5;
    localparam int RESET_CYCLES = 8;

    initial begin
        aclk = 1'b0;
        forever #HALF_PERIOD aclk = ~aclk;
    end

    initial begin
        areset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #1 areset = 1'b0;
    end

endmodule

// ==== test/axi_bridge_checker.sv ====
`timescale 1ns/1ns

module axi_bridge_checker (
    input logic aclk,
    input logic areset,
    input logic inst_fetch_flag,
    input logic mem_access_flag,
    input logic access_fault,
    input logic soc_awvalid,
    input logic soc_wvalid,
    input logic soc_arvalid,
    input logic clint_arvalid,
    input logic ifu_arready,
    input logic ifu_rvalid
);
    logic mem_sel;
    int   violations = 0;

    // follows the last flag the core raised
    always_ff @(posedge aclk) begin
        if (areset) begin
            mem_sel <= 1'b0;
        end else if (mem_access_flag) begin
            mem_sel <= 1'b1;
        end else if (inst_fetch_flag) begin
            mem_sel <= 1'b0;
        end
    end

    one_read_target: assert property (@(posedge aclk) disable iff (areset)
        !(soc_arvalid && clint_arvalid))
        else begin
            $error("read address sent to soc and clint at once");
            violations++;
        end

    fault_blocks_slaves: assert property (@(posedge aclk) disable iff (areset)
        access_fault |-> !soc_awvalid && !soc_wvalid && !soc_arvalid && !clint_arvalid)
        else begin
            $error("faulting request reached a slave");
            violations++;
        end

    ifu_blocked_in_mem: assert property (@(posedge aclk) disable iff (areset)
        mem_sel |-> !ifu_arready && !ifu_rvalid)
        else begin
            $error("ifu served while memory access owns the bus");
            violations++;
        end

endmodule

// ==== test/axi_bridge_tb.sv ====
`timescale 1ns/1ns

module axi_bridge_tb;
    import bridge_pkg::*;

    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int CLK_PERIOD = 10;
    localparam int HS_LIMIT = 50; // cycles to wait for one handshake

    logic aclk, areset, inst_fetch_flag, mem_access_flag, access_fault;
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid, lsu_bready;
    logic lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic soc_awvalid, soc_awready, soc_wvalid, soc_wready, soc_bvalid, soc_bready;
    logic soc_arvalid, soc_arready, soc_rvalid, soc_rready;
    logic clint_arvalid, clint_arready, clint_rvalid, clint_rready;
    addr_req_t lsu_awreq, lsu_arreq, ifu_arreq, soc_awreq, soc_arreq;
    wdata_t    lsu_w, soc_w;
    bresp_t    lsu_b, soc_b;
    rdata_t    lsu_r, ifu_r, soc_r, clint_r;
    logic [ADDR_WIDTH-1:0] clint_araddr;

    integer      seed;
    int          errors = 0;
    int          errors_at_start = 0;
    int          test_num = 0;
    int          tests_failed = 0;
    bit          ifu_phase = 1'b0;
    logic [31:0] soc_mem [logic [31:0]]; // soc writes by address

    clock_gen u_clock_gen (.aclk(aclk), .areset(areset));

    axi_bridge u_axi_bridge (.*);

    bind axi_bridge axi_bridge_checker u_checker (.*);

    no_lsu_read_in_fetch: assert property (@(posedge aclk) disable iff (areset)
        ifu_phase |-> !lsu_rvalid)
        else begin
            $display("ERR %0t: lsu saw rvalid during ifu fetch", $time);
            errors++;
        end

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic finish_test(input string name);
        test_num++;
        if (errors == errors_at_start) begin
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: failed with %0d errors", test_num, name,
                     errors - errors_at_start);
            tests_failed++;
        end
        errors_at_start = errors;
    endtask

    function automatic logic [31:0] apply_strb(input logic [31:0] data, input logic [3:0] strb);
        logic [31:0] res;
        res = '0;
        for (int i = 0; i < 4; i++) begin
            if (strb[i]) res[i*8 +: 8] = data[i*8 +: 8];
        end
        return res;
    endfunction

    task automatic pulse_flag(input bit mem);
        if (mem) mem_access_flag = 1'b1;
        else inst_fetch_flag = 1'b1;
        @(posedge aclk);
        #1;
        mem_access_flag = 1'b0;
        inst_fetch_flag = 1'b0;
        @(posedge aclk);
        #1;
    endtask

    task automatic do_read(input bit from_ifu, input logic [31:0] addr, input int hold,
                           input bit to_clint);
        logic [31:0] exp_data;
        rdata_t      got;
        int          cnt;
        bit          done;
        exp_data = to_clint ? addr + 32'h5a5a_0000 : ~addr;
        if (from_ifu) begin
            ifu_arvalid = 1'b1;
            ifu_arreq   = '{addr, 3'd2, 3'd0};
        end else begin
            lsu_arvalid = 1'b1;
            lsu_arreq   = '{addr, 3'd2, 3'd0};
        end
        cnt = 0;
        done = 1'b0;
        while (!done && cnt < HS_LIMIT) begin
            @(posedge aclk);
            done = from_ifu ? ifu_arready : lsu_arready;
            cnt++;
        end
        if (done && to_clint) begin
            assert (clint_arvalid && !soc_arvalid && clint_araddr == addr)
            else report_mismatch($sformatf("read %h not seen on clint port", addr));
        end else if (done) begin
            assert (soc_arvalid && !clint_arvalid && soc_arreq.addr == addr)
            else report_mismatch($sformatf("read %h not seen on soc port", addr));
        end
        #1;
        ifu_arvalid = 1'b0;
        lsu_arvalid = 1'b0;
        if (!done) begin
            $display("read address %h was never accepted", addr);
            errors++;
            return;
        end
        repeat (hold) begin
            @(posedge aclk);
            #1;
        end
        ifu_rready = from_ifu;
        lsu_rready = !from_ifu;
        cnt = 0;
        done = 1'b0;
        while (!done && cnt < HS_LIMIT) begin
            @(posedge aclk);
            done = from_ifu ? ifu_rvalid : lsu_rvalid;
            got  = from_ifu ? ifu_r : lsu_r;
            cnt++;
        end
        #1;
        ifu_rready = 1'b0;
        lsu_rready = 1'b0;
        if (!done) begin
            $display("no read response came back for %h", addr);
            errors++;
        end else begin
            assert (got.data == exp_data && got.resp == 2'b00)
            else report_mismatch($sformatf("read %h gave %h, expected %h",
                                           addr, got.data, exp_data));
        end
    endtask

    task automatic do_write(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
        int cnt;
        bit aw_done;
        bit w_done;
        bit b_done;
        lsu_awvalid = 1'b1;
        lsu_awreq   = '{addr, 3'd2, 3'd0};
        lsu_wvalid  = 1'b1;
        lsu_w       = '{data, strb};
        cnt = 0;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done) && cnt < HS_LIMIT) begin
            @(posedge aclk);
            if (lsu_awvalid && lsu_awready) begin
                aw_done = 1'b1;
                assert (soc_awvalid && soc_awreq.addr == addr)
                else report_mismatch($sformatf("write address %h not seen on soc", addr));
            end
            if (lsu_wvalid && lsu_wready) w_done = 1'b1;
            #1;
            if (aw_done) lsu_awvalid = 1'b0;
            if (w_done) lsu_wvalid = 1'b0;
            cnt++;
        end
        lsu_bready = 1'b1;
        cnt = 0;
        b_done = 1'b0;
        while (aw_done && w_done && !b_done && cnt < HS_LIMIT) begin
            @(posedge aclk);
            b_done = lsu_bvalid;
            if (b_done) begin
                assert (lsu_b == 2'b00)
                else report_mismatch("write response code not okay");
            end
            cnt++;
        end
        #1;
        lsu_bready  = 1'b0;
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        if (!b_done) begin
            $display("write to %h did not complete", addr);
            errors++;
        end else begin
            assert (soc_mem.exists(addr) && soc_mem[addr] == apply_strb(data, strb))
            else report_mismatch($sformatf("write to %h not stored as expected", addr));
        end
    endtask

    // hold a request that maps nowhere, then give up on it
    task automatic fault_request(input bit is_write, input logic [31:0] addr);
        lsu_awvalid = is_write;
        lsu_wvalid  = is_write;
        lsu_awreq   = '{addr, 3'd2, 3'd0};
        lsu_w       = '{32'h1234_5678, 4'hf};
        lsu_arvalid = !is_write;
        lsu_arreq   = '{addr, 3'd2, 3'd0};
        repeat (4) begin
            @(posedge aclk);
            assert (access_fault && !lsu_awready && !lsu_wready && !lsu_arready)
            else report_mismatch($sformatf("request to %h not faulted", addr));
        end
        #1;
        lsu_awvalid = 1'b0;
        lsu_wvalid  = 1'b0;
        lsu_arvalid = 1'b0;
        @(posedge aclk);
        assert (!access_fault)
        else report_mismatch("access_fault stayed high after request dropped");
        #1;
    endtask

    initial begin : soc_read_model
        logic [31:0] raddr;
        int          lat;
        soc_arready = 1'b1;
        soc_rvalid  = 1'b0;
        soc_r       = '0;
        forever begin
            @(posedge aclk);
            if (!areset && soc_arvalid && soc_arready) begin
                raddr = soc_arreq.addr;
                lat = $unsigned($random(seed)) % 4;
                #1 soc_arready = 1'b0;
                repeat (lat) @(posedge aclk);
                if (lat > 0) #1;
                soc_rvalid = 1'b1;
                soc_r      = '{~raddr, 2'b00}; // data is the inverted address
                do @(posedge aclk); while (!soc_rready);
                #1;
                soc_rvalid  = 1'b0;
                soc_r       = '0;
                soc_arready = 1'b1;
            end
        end
    end

    initial begin : soc_write_model
        logic [31:0] waddr;
        wdata_t      wbeat;
        bit          got_aw;
        bit          got_w;
        int          lat;
        soc_awready = 1'b1;
        soc_wready  = 1'b1;
        soc_bvalid  = 1'b0;
        soc_b       = '0;
        forever begin
            got_aw = 1'b0;
            got_w = 1'b0;
            while (!(got_aw && got_w)) begin
                @(posedge aclk);
                if (!areset && soc_awvalid && soc_awready) begin
                    got_aw = 1'b1;
                    waddr  = soc_awreq.addr;
                end
                if (!areset && soc_wvalid && soc_wready) begin
                    got_w = 1'b1;
                    wbeat = soc_w;
                end
                #1;
                soc_awready = !got_aw;
                soc_wready  = !got_w;
            end
            soc_mem[waddr] = apply_strb(wbeat.data, wbeat.strb);
            lat = $unsigned($random(seed)) % 4;
            repeat (lat) begin
                @(posedge aclk);
                #1;
            end
            soc_bvalid = 1'b1;
            do @(posedge aclk); while (!soc_bready);
            #1;
            soc_bvalid  = 1'b0;
            soc_awready = 1'b1;
            soc_wready  = 1'b1;
        end
    end

    initial begin : clint_model
        logic [31:0] raddr;
        int          lat;
        clint_arready = 1'b1;
        clint_rvalid  = 1'b0;
        clint_r       = '0;
        forever begin
            @(posedge aclk);
            if (!areset && clint_arvalid && clint_arready) begin
                raddr = clint_araddr;
                lat = $unsigned($random(seed)) % 4;
                #1 clint_arready = 1'b0;
                repeat (lat) @(posedge aclk);
                if (lat > 0) #1;
                clint_rvalid = 1'b1;
                clint_r      = '{raddr + 32'h5a5a_0000, 2'b00};
                do @(posedge aclk); while (!clint_rready);
                #1;
                clint_rvalid  = 1'b0;
                clint_r       = '0;
                clint_arready = 1'b1;
            end
        end
    end

    initial begin : watchdog
        #(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
        $display("run stopped by watchdog, a test hung");
        $display("Simulation failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addr;
        int          hold;
        seed = 32'h259f_73f0;
        inst_fetch_flag = 1'b0;
        mem_access_flag = 1'b0;
        lsu_awvalid = 1'b0;
        lsu_awreq   = '0;
        lsu_wvalid  = 1'b0;
        lsu_w       = '0;
        lsu_bready  = 1'b0;
        lsu_arvalid = 1'b0;
        lsu_arreq   = '0;
        lsu_rready  = 1'b0;
        ifu_arvalid = 1'b0;
        ifu_arreq   = '0;
        ifu_rready  = 1'b0;
        wait (areset == 1'b0);
        @(posedge aclk);
        #1;

        ifu_phase = 1'b1;
        do_read(1'b1, 32'h0f00_0100, 0, 1'b0);
        do_read(1'b1, 32'h3000_0040, 1, 1'b0);
        ifu_phase = 1'b0;
        finish_test("ifu fetch to soc");

        pulse_flag(1'b1);
        do_write(32'h1000_0010, 32'hdead_beef, 4'b0101);
        do_read(1'b0, 32'h1000_0010, 0, 1'b0);
        finish_test("lsu write and read-back");

        do_read(1'b0, 32'h0200_4000, 0, 1'b1);
        finish_test("lsu clint read");

        fault_request(1'b1, 32'h2000_0000);
        fault_request(1'b1, 32'h0200_0000);
        fault_request(1'b0, 32'h8000_0000);
        finish_test("access faults");

        for (int i = 0; i < 6; i++) begin
            hold = $unsigned($random(seed)) % 5;
            if (i % 2 == 1) begin
                addr = CLINT_BASE + ($unsigned($random(seed)) & 32'h0000_fffc);
            end else begin
                addr = SRAM_BASE + ($unsigned($random(seed)) & 32'h0000_1ffc);
            end
            do_read(1'b0, addr, hold, i % 2 == 1);
        end
        pulse_flag(1'b0);
        for (int i = 0; i < 3; i++) begin
            hold = $unsigned($random(seed)) % 5;
            addr = FLASH_BASE + ($unsigned($random(seed)) & 32'h00ff_fffc);
            do_read(1'b1, addr, hold, 1'b0);
        end
        finish_test("back-pressure and route holding");

        $display("tests run %0d, tests failed %0d, errors %0d, checker violations %0d",
                 test_num, tests_failed, errors, u_axi_bridge.u_checker.violations);
        if (errors == 0 && u_axi_bridge.u_checker.violations == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== files.f ====
logic/bridge_pkg.sv
logic/master_arbiter.sv
logic/addr_decoder.sv
logic/slave_router.sv
logic/axi_bridge.sv
test/clock_gen.sv
test/axi_bridge_checker.sv
test/axi_bridge_tb.sv

// ==== Makefile ====
TOOL     := verilator
FLAGS    := --binary --timing --assert
TOP      := axi_bridge_tb
FILELIST := files.f
BUILD    := obj_dir
LOG      := sim.log
PASS     := Simulation passed

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) +verilator+error+limit+100 > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
